// File: design/overworld_macros.svh
`ifndef OVERWORLD_MACROS_SVH
`define OVERWORLD_MACROS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define COORD_W 10
`define KEY_W 8

// walkable area edges, screen pixels
`define AREA_X_MIN 10'd79
`define AREA_X_MAX 10'd639
`define AREA_Y_MIN 10'd215
`define AREA_Y_MAX 10'd295

// player box
`define PLAYER_W 10'd16
`define PLAYER_H 10'd20
`define START_X 10'd79
`define START_Y 10'd215

// usb hid keycodes
`define KEY_UP 8'h52
`define KEY_DOWN 8'h51
`define KEY_LEFT 8'h50
`define KEY_RIGHT 8'h4F
`define KEY_CATCH 8'h06
`define KEY_RUN 8'h15

// sprite offset within one facing direction
`define SPR_STAND 2'd0
`define SPR_WALK_HI 2'd1
`define SPR_WALK_LO 2'd2

// animation limits, in ticks
`define WALK_WRAP 6'd32
`define WALK_HALF 5'd16
`define THROW_END 7'd64
`define BALL_F2 7'd16
`define BALL_F3 7'd32
`define BALL_END 8'd80

// apb register map
`define REG_SPEED 4'h0
`define REG_CREATURE_POS 4'h4
`define REG_CREATURE_SIZE 4'h8
`define REG_STATUS 4'hC

`endif

// File: design/overworld_pkg.sv
`include "overworld_macros.svh"

package overworld_pkg;

    // --------------------------------------------------
    // geometry
    // --------------------------------------------------
    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } pos_t;

    typedef struct packed {
        logic [`COORD_W-1:0] w;
        logic [`COORD_W-1:0] h;
    } size_t;

    // top-left corner plus extent
    typedef struct packed {
        pos_t  pos;
        size_t size;
    } box_t;

    // register block outputs
    typedef struct packed {
        logic [1:0] speed;
        box_t       creature;
        logic       present;
    } cfg_t;

    // order sets the sprite group, three codes each
    typedef enum logic [1:0] {
        dir_down  = 2'd0,
        dir_up    = 2'd1,
        dir_left  = 2'd2,
        dir_right = 2'd3
    } dir_t;

    // --------------------------------------------------
    // apb
    // --------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef logic [3:0] sprite_t;

endpackage

// File: design/overworld_regs.sv
`timescale 1ns/1ns
`include "overworld_macros.svh"

module overworld_regs (
    input  logic                     frame_clk,
    input  logic                     Reset,
    input  overworld_pkg::apb_req_t  apb,
    output overworld_pkg::apb_rsp_t  apb_rsp,
    input  logic                     caught,
    input  logic [7:0]               caught_count,
    output overworld_pkg::cfg_t      cfg
);
    import overworld_pkg::*;

    localparam int PAD = 16 - `COORD_W;

    logic        access;
    logic        wr;
    logic        speed_ok;
    logic        err;
    logic [31:0] rdata;

    // access phase of a transfer, no wait states
    assign access = apb.psel && apb.penable;
    assign wr = access && apb.pwrite;
    // only 1x and 2x walking
    assign speed_ok = (apb.pwdata == 32'd1) || (apb.pwdata == 32'd2);

    // --------------------------------------------------
    // error decode
    // --------------------------------------------------
    always_comb
    begin
        err = 1'b0;
        if (wr)
        begin
            case (apb.paddr)
                `REG_SPEED:         err = !speed_ok;
                `REG_CREATURE_POS:  err = 1'b0;
                `REG_CREATURE_SIZE: err = 1'b0;
                // status is read only
                default:            err = 1'b1;
            endcase
        end
    end

    // readback mux, x in low half and y in high half
    always_comb
    begin
        case (apb.paddr)
            `REG_SPEED:
                rdata = {30'd0, cfg.speed};
            `REG_CREATURE_POS:
                rdata = {{PAD{1'b0}}, cfg.creature.pos.y, {PAD{1'b0}}, cfg.creature.pos.x};
            `REG_CREATURE_SIZE:
                rdata = {{PAD{1'b0}}, cfg.creature.size.h, {PAD{1'b0}}, cfg.creature.size.w};
            `REG_STATUS:
                rdata = {16'd0, caught_count, 7'd0, cfg.present};
            default:
                rdata = 32'd0;
        endcase
    end

    assign apb_rsp.prdata = rdata;
    assign apb_rsp.pready = 1'b1;
    assign apb_rsp.pslverr = err;

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge frame_clk or posedge Reset)
    begin
        if (Reset)
        begin
            cfg.speed <= 2'd1;
            cfg.creature <= '0;
            cfg.present <= 1'b0;
        end
        else
        begin
            // a catch removes the creature
            if (caught)
                cfg.present <= 1'b0;
            if (wr && !err)
            begin
                case (apb.paddr)
                    `REG_SPEED:
                        cfg.speed <= apb.pwdata[1:0];
                    `REG_CREATURE_POS:
                    begin
                        cfg.creature.pos.x <= apb.pwdata[`COORD_W-1:0];
                        cfg.creature.pos.y <= apb.pwdata[16+`COORD_W-1:16];
                        // placing it again re-arms the encounter
                        cfg.present <= 1'b1;
                    end
                    `REG_CREATURE_SIZE:
                    begin
                        cfg.creature.size.w <= apb.pwdata[`COORD_W-1:0];
                        cfg.creature.size.h <= apb.pwdata[16+`COORD_W-1:16];
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

// File: design/walker.sv
`timescale 1ns/1ns
`include "overworld_macros.svh"

module walker (
    input  logic                    frame_clk,
    input  logic                    Reset,
    input  logic [`KEY_W-1:0]       keycode,
    input  overworld_pkg::cfg_t     cfg,
    input  logic                    fight,
    output overworld_pkg::pos_t     pos,
    output overworld_pkg::sprite_t  sprite,
    output logic                    started,
    output logic                    encounter
);
    import overworld_pkg::*;

    logic                arrow;
    dir_t                key_dir;
    dir_t                last_dir;
    logic                moving;
    pos_t                next_pos;
    logic [`COORD_W-1:0] step;
    logic [`COORD_W:0]   nx_end;
    logic [`COORD_W:0]   ny_end;
    logic [`COORD_W:0]   cx_end;
    logic [`COORD_W:0]   cy_end;
    logic                overlap;
    logic [4:0]          walk_cnt;
    logic [5:0]          walk_sum;
    logic [5:0]          walk_next;
    logic [1:0]          frame;

    // three codes per facing direction
    function automatic sprite_t sprite_code(input dir_t d, input logic [1:0] f);
        sprite_t base;
        base = {2'b00, d};
        return base * 4'd3 + {2'b00, f};
    endfunction

    // --------------------------------------------------
    // key decode
    // --------------------------------------------------
    always_comb
    begin
        arrow = 1'b1;
        key_dir = last_dir;
        case (keycode)
            `KEY_UP:    key_dir = dir_up;
            `KEY_DOWN:  key_dir = dir_down;
            `KEY_LEFT:  key_dir = dir_left;
            `KEY_RIGHT: key_dir = dir_right;
            default:    arrow = 1'b0;
        endcase
    end

    assign moving = started && !fight && arrow;
    assign step = {{(`COORD_W-2){1'b0}}, cfg.speed};

    // next position, clamped so the whole box stays inside
    always_comb
    begin
        next_pos = pos;
        case (key_dir)
            dir_up:
                if (pos.y < `AREA_Y_MIN + step)
                    next_pos.y = `AREA_Y_MIN;
                else
                    next_pos.y = pos.y - step;
            dir_down:
                if (pos.y + step > `AREA_Y_MAX - `PLAYER_H)
                    next_pos.y = `AREA_Y_MAX - `PLAYER_H;
                else
                    next_pos.y = pos.y + step;
            dir_left:
                if (pos.x < `AREA_X_MIN + step)
                    next_pos.x = `AREA_X_MIN;
                else
                    next_pos.x = pos.x - step;
            default:
                if (pos.x + step > `AREA_X_MAX - `PLAYER_W)
                    next_pos.x = `AREA_X_MAX - `PLAYER_W;
                else
                    next_pos.x = pos.x + step;
        endcase
    end

    // --------------------------------------------------
    // creature overlap
    // --------------------------------------------------
    // one extra bit so far edges cannot wrap
    assign nx_end = {1'b0, next_pos.x} + `PLAYER_W;
    assign ny_end = {1'b0, next_pos.y} + `PLAYER_H;
    assign cx_end = {1'b0, cfg.creature.pos.x} + {1'b0, cfg.creature.size.w};
    assign cy_end = {1'b0, cfg.creature.pos.y} + {1'b0, cfg.creature.size.h};
    assign overlap = (next_pos.x < cx_end) && (cfg.creature.pos.x < nx_end)
                  && (next_pos.y < cy_end) && (cfg.creature.pos.y < ny_end);
    // fight rises on this edge, so high for one cycle only
    assign encounter = moving && cfg.present && overlap;

    // walk counter wraps at 32
    assign walk_sum = {1'b0, walk_cnt} + {4'd0, cfg.speed};
    assign walk_next = (walk_sum >= `WALK_WRAP) ? walk_sum - `WALK_WRAP : walk_sum;
    assign frame = (walk_cnt >= `WALK_HALF) ? `SPR_WALK_HI : `SPR_WALK_LO;

    // --------------------------------------------------
    // state
    // --------------------------------------------------
    always_ff @(posedge frame_clk or posedge Reset)
    begin
        if (Reset)
        begin
            pos.x <= `START_X;
            pos.y <= `START_Y;
            last_dir <= dir_down;
            walk_cnt <= 5'd0;
            started <= 1'b0;
            sprite <= '0;
        end
        else
        begin
            // any key starts the game, motion from next frame on
            if (!started && keycode != '0)
                started <= 1'b1;
            if (moving)
            begin
                last_dir <= key_dir;
                walk_cnt <= walk_next[4:0];
                sprite <= sprite_code(key_dir, frame);
                // bumping the creature holds the player in place
                if (!encounter)
                    pos <= next_pos;
            end
            else
                sprite <= sprite_code(last_dir, `SPR_STAND);
        end
    end

endmodule

// File: design/catch_sequencer.sv
`timescale 1ns/1ns
`include "overworld_macros.svh"

module catch_sequencer (
    input  logic                 frame_clk,
    input  logic                 Reset,
    input  logic [`KEY_W-1:0]    keycode,
    input  overworld_pkg::cfg_t  cfg,
    input  logic                 encounter,
    output logic                 fight,
    output logic [2:0]           throw_frame,
    output logic [1:0]           ball_frame,
    output logic                 caught,
    output logic [7:0]           caught_count
);
    import overworld_pkg::*;

    logic       throwing;
    logic [6:0] throw_tick;
    logic [6:0] ball_tick;
    logic [6:0] step;
    logic [7:0] ball_sum;
    logic       in_ball;

    assign step = {5'd0, cfg.speed};
    // throw animation done, ball wobbling
    assign in_ball = throw_tick >= `THROW_END;
    assign ball_sum = {1'b0, ball_tick} + {1'b0, step};

    // last wobble tick, fight and present fall on the same edge
    assign caught = throwing && in_ball && (ball_sum >= `BALL_END);

    // --------------------------------------------------
    // animation frames
    // --------------------------------------------------
    // four throw frames of 16 ticks each
    assign throw_frame = (throwing && !in_ball) ? {1'b0, throw_tick[5:4]} + 3'd1 : 3'd0;

    always_comb
    begin
        ball_frame = 2'd0;
        if (throwing && in_ball)
        begin
            if (ball_tick < `BALL_F2)
                ball_frame = 2'd1;
            else if (ball_tick < `BALL_F3)
                ball_frame = 2'd2;
            else
                ball_frame = 2'd3;
        end
    end

    // --------------------------------------------------
    // encounter state
    // --------------------------------------------------
    always_ff @(posedge frame_clk or posedge Reset)
    begin
        if (Reset)
        begin
            fight <= 1'b0;
            throwing <= 1'b0;
            throw_tick <= 7'd0;
            ball_tick <= 7'd0;
            caught_count <= 8'd0;
        end
        else if (caught)
        begin
            fight <= 1'b0;
            throwing <= 1'b0;
            throw_tick <= 7'd0;
            ball_tick <= 7'd0;
            caught_count <= caught_count + 8'd1;
        end
        else if (throwing)
        begin
            // keys are ignored until the ball settles
            if (!in_ball)
                throw_tick <= throw_tick + step;
            else
                ball_tick <= ball_sum[6:0];
        end
        else if (fight)
        begin
            if (keycode == `KEY_CATCH)
            begin
                throwing <= 1'b1;
                throw_tick <= 7'd0;
                ball_tick <= 7'd0;
            end
            // escape, count unchanged
            else if (keycode == `KEY_RUN)
                fight <= 1'b0;
        end
        else if (encounter)
            fight <= 1'b1;
    end

endmodule

// File: design/overworld_top.sv
`timescale 1ns/1ns
`include "overworld_macros.svh"

module overworld_top (
    input  logic                     frame_clk,
    input  logic                     Reset,
    input  logic [`KEY_W-1:0]        keycode,
    input  overworld_pkg::apb_req_t  apb,
    output overworld_pkg::apb_rsp_t  apb_rsp,
    output overworld_pkg::pos_t      pos,
    output overworld_pkg::sprite_t   sprite,
    output logic                     started,
    output logic                     fight,
    output logic [2:0]               throw_frame,
    output logic [1:0]               ball_frame,
    output logic [7:0]               caught_count
);
    import overworld_pkg::*;

    // speed, creature box and present flag
    cfg_t cfg;
    // one-cycle handshakes between the blocks
    logic caught;
    logic encounter;

    // --------------------------------------------------
    // register block
    // --------------------------------------------------
    overworld_regs u_regs (
        .frame_clk    (frame_clk),
        .Reset        (Reset),
        .apb          (apb),
        .apb_rsp      (apb_rsp),
        .caught       (caught),
        .caught_count (caught_count),
        .cfg          (cfg)
    );

    // overworld motion
    walker u_walker (
        .frame_clk (frame_clk),
        .Reset     (Reset),
        .keycode   (keycode),
        .cfg       (cfg),
        .fight     (fight),
        .pos       (pos),
        .sprite    (sprite),
        .started   (started),
        .encounter (encounter)
    );

    // encounter and catch
    catch_sequencer u_catch (
        .frame_clk    (frame_clk),
        .Reset        (Reset),
        .keycode      (keycode),
        .cfg          (cfg),
        .encounter    (encounter),
        .fight        (fight),
        .throw_frame  (throw_frame),
        .ball_frame   (ball_frame),
        .caught       (caught),
        .caught_count (caught_count)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic frame_clk,
    output logic Reset
);

    // 10 ns frame clock
    initial
    begin
        frame_clk = 1'b0;
        forever #5 frame_clk = ~frame_clk;
    end

    // reset held for four rising edges, released just after the fourth
    initial
    begin
        Reset = 1'b1;
        repeat (4) @(posedge frame_clk);
        #1 Reset = 1'b0;
    end

endmodule

// File: testbench/overworld_asserts.sv
`timescale 1ns/1ns

module overworld_asserts (
    input logic                     frame_clk,
    input logic                     Reset,
    input overworld_pkg::apb_rsp_t  apb_rsp,
    input logic                     started,
    input logic                     fight,
    input logic [2:0]               throw_frame,
    input logic [1:0]               ball_frame
);

    // read by the testbench for the final verdict
    int fail_count = 0;

    // --------------------------------------------------
    // apb
    // --------------------------------------------------
    // zero wait states
    pready_high: assert property (@(posedge frame_clk) apb_rsp.pready)
    else
    begin
        $error("apb pready went low");
        fail_count++;
    end

    // --------------------------------------------------
    // encounter
    // --------------------------------------------------
    // animation only while in a fight
    frames_need_fight: assert property (@(posedge frame_clk) disable iff (Reset)
        (throw_frame != 3'd0 || ball_frame != 2'd0) |-> fight)
    else
    begin
        $error("throw or ball frame active outside a fight");
        fail_count++;
    end

    // state held clear in reset
    reset_clears: assert property (@(posedge frame_clk) Reset |-> (!fight && !started))
    else
    begin
        $error("fight or started high during reset");
        fail_count++;
    end

endmodule

bind overworld_top overworld_asserts u_asserts (
    .frame_clk   (frame_clk),
    .Reset       (Reset),
    .apb_rsp     (apb_rsp),
    .started     (started),
    .fight       (fight),
    .throw_frame (throw_frame),
    .ball_frame  (ball_frame)
);

// File: testbench/overworld_tb.sv
`timescale 1ns/1ns
`include "overworld_macros.svh"

module overworld_tb;
    import overworld_pkg::*;

    // cycle budget of 16 hold cycles per segment plus a speed write
    localparam int RAND_SEGS = 40;
    localparam int RAND_CYCLES = 2 * RAND_SEGS * 18;
    localparam int DIRECTED_CYCLES = 440;
    localparam int CATCH_CYCLES = int'(`THROW_END) + int'(`BALL_END);
    localparam int CYCLE_LIMIT = (RAND_CYCLES + DIRECTED_CYCLES + CATCH_CYCLES) * 2;

    logic              frame_clk;
    logic              Reset;
    logic [`KEY_W-1:0] keycode;
    apb_req_t          apb;
    apb_rsp_t          apb_rsp;
    pos_t              pos;
    sprite_t           sprite;
    logic              started;
    logic              fight;
    logic [2:0]        throw_frame;
    logic [1:0]        ball_frame;
    logic [7:0]        caught_count;

    // reference model state
    int          m_x;
    int          m_y;
    int          m_dir;
    int          m_walk;
    int          m_sprite;
    int          m_speed;
    int          m_count;
    logic        m_started;
    logic        m_fight;
    logic        m_present;
    int          cr_x;
    int          cr_y;
    int          cr_w;
    int          cr_h;
    // fight and count not modelled while the ball is out
    logic        in_throw;
    logic [15:0] lfsr;
    int          errors;
    int          cycles;

    tb_clock u_clock (
        .frame_clk (frame_clk),
        .Reset     (Reset)
    );

    overworld_top uut (
        .frame_clk    (frame_clk),
        .Reset        (Reset),
        .keycode      (keycode),
        .apb          (apb),
        .apb_rsp      (apb_rsp),
        .pos          (pos),
        .sprite       (sprite),
        .started      (started),
        .fight        (fight),
        .throw_frame  (throw_frame),
        .ball_frame   (ball_frame),
        .caught_count (caught_count)
    );

    // --------------------------------------------------
    // random bits
    // --------------------------------------------------
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        repeat (n)
        begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // 0 down, 1 up, 2 left, 3 right, -1 not an arrow
    function automatic int arrow_dir(input logic [7:0] k);
        case (k)
            `KEY_DOWN:  return 0;
            `KEY_UP:    return 1;
            `KEY_LEFT:  return 2;
            `KEY_RIGHT: return 3;
            default:    return -1;
        endcase
    endfunction

    function automatic logic [7:0] dir_key(input int d);
        case (d)
            0:       return `KEY_DOWN;
            1:       return `KEY_UP;
            2:       return `KEY_LEFT;
            default: return `KEY_RIGHT;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs();
        check("pos.x", 32'(pos.x), m_x);
        check("pos.y", 32'(pos.y), m_y);
        check("sprite", 32'(sprite), m_sprite);
        check("started", 32'(started), 32'(m_started));
        if (!in_throw)
        begin
            check("fight", 32'(fight), 32'(m_fight));
            check("caught_count", 32'(caught_count), m_count);
        end
    endtask

    // --------------------------------------------------
    // model of one frame edge
    // --------------------------------------------------
    task automatic model_edge(input logic [7:0] k);
        int   d;
        int   nx;
        int   ny;
        logic hit;
        d = arrow_dir(k);
        if (m_started && !m_fight && d >= 0)
        begin
            nx = m_x;
            ny = m_y;
            // clamp so the whole player box stays in the area
            case (d)
                0:
                begin
                    ny = m_y + m_speed;
                    if (ny > int'(`AREA_Y_MAX) - int'(`PLAYER_H))
                        ny = int'(`AREA_Y_MAX) - int'(`PLAYER_H);
                end
                1:
                begin
                    ny = m_y - m_speed;
                    if (ny < int'(`AREA_Y_MIN))
                        ny = int'(`AREA_Y_MIN);
                end
                2:
                begin
                    nx = m_x - m_speed;
                    if (nx < int'(`AREA_X_MIN))
                        nx = int'(`AREA_X_MIN);
                end
                default:
                begin
                    nx = m_x + m_speed;
                    if (nx > int'(`AREA_X_MAX) - int'(`PLAYER_W))
                        nx = int'(`AREA_X_MAX) - int'(`PLAYER_W);
                end
            endcase
            hit = m_present && nx < cr_x + cr_w && cr_x < nx + int'(`PLAYER_W)
                && ny < cr_y + cr_h && cr_y < ny + int'(`PLAYER_H);
            // frame from the count before it steps
            m_sprite = d * 3 + ((m_walk >= 16) ? 1 : 2);
            m_walk = (m_walk + m_speed) % 32;
            m_dir = d;
            if (hit)
                m_fight = 1'b1;
            else
            begin
                m_x = nx;
                m_y = ny;
            end
        end
        else
        begin
            m_sprite = m_dir * 3;
            if (m_fight && k == `KEY_RUN)
                m_fight = 1'b0;
        end
        if (k != 8'd0)
            m_started = 1'b1;
    endtask

    task automatic clock_edge();
        model_edge(keycode);
        @(posedge frame_clk);
        #1;
        check_outputs();
    endtask

    task automatic hold_key(input logic [7:0] k, input int n);
        keycode = k;
        repeat (n)
            clock_edge();
    endtask

    // --------------------------------------------------
    // apb transfer with expected response
    // --------------------------------------------------
    task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata);
        logic        exp_err;
        logic [31:0] exp_rd;
        exp_err = 1'b0;
        exp_rd = 32'd0;
        case (addr)
            `REG_SPEED:
            begin
                exp_rd = 32'(m_speed);
                exp_err = write && wdata != 32'd1 && wdata != 32'd2;
            end
            `REG_CREATURE_POS:
                exp_rd = {16'(cr_y), 16'(cr_x)};
            `REG_CREATURE_SIZE:
                exp_rd = {16'(cr_h), 16'(cr_w)};
            `REG_STATUS:
            begin
                exp_rd = {16'd0, 8'(m_count), 7'd0, m_present};
                exp_err = write;
            end
            default:
                exp_err = write;
        endcase
        // setup phase
        apb.psel = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite = write;
        apb.paddr = addr;
        apb.pwdata = wdata;
        clock_edge();
        apb.penable = 1'b1;
        #1;
        check("pready", 32'(apb_rsp.pready), 32'd1);
        check("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
        if (!write)
            check("prdata", apb_rsp.prdata, exp_rd);
        // write lands on the access edge
        clock_edge();
        if (write && !exp_err)
        begin
            case (addr)
                `REG_SPEED:
                    m_speed = int'(wdata[1:0]);
                `REG_CREATURE_POS:
                begin
                    cr_x = int'(wdata[`COORD_W-1:0]);
                    cr_y = int'(wdata[16+`COORD_W-1:16]);
                    m_present = 1'b1;
                end
                `REG_CREATURE_SIZE:
                begin
                    cr_w = int'(wdata[`COORD_W-1:0]);
                    cr_h = int'(wdata[16+`COORD_W-1:16]);
                end
                default:
                begin
                end
            endcase
        end
        apb = '0;
    endtask

    // arrow keys in half the segments and idle or C or R in the rest
    task automatic random_walk(input int segs);
        int         cls;
        int         len;
        logic [7:0] k;
        repeat (segs)
        begin
            if (rand_bits(3) == 0)
                apb_xfer(1'b1, `REG_SPEED, 32'(rand_bits(1) + 1));
            cls = rand_bits(3);
            len = rand_bits(4) + 1;
            case (cls)
                0, 1, 2, 3: k = dir_key(rand_bits(2));
                4, 5:       k = 8'd0;
                6:          k = `KEY_CATCH;
                default:    k = `KEY_RUN;
            endcase
            hold_key(k, len);
        end
    endtask

    // throw the ball and wait for fight to fall after one more catch
    task automatic catch_creature();
        int waited;
        int max_ball;
        keycode = `KEY_CATCH;
        clock_edge();
        check("throw_frame", 32'(throw_frame), 32'd1);
        keycode = 8'd0;
        in_throw = 1'b1;
        waited = 0;
        max_ball = 0;
        while (fight && waited < CATCH_CYCLES)
        begin
            clock_edge();
            waited++;
            if (int'(ball_frame) > max_ball)
                max_ball = int'(ball_frame);
        end
        in_throw = 1'b0;
        if (fight)
        begin
            errors++;
            $display("catch did not finish within %0d cycles", CATCH_CYCLES);
        end
        check("peak ball_frame", max_ball, 32'd3);
        m_fight = 1'b0;
        m_count++;
        m_present = 1'b0;
        check_outputs();
    endtask

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge frame_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d, assertion failures: %0d", errors, uut.u_asserts.fail_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        keycode = 8'd0;
        apb = '0;
        lfsr = 16'd21;
        errors = 0;
        in_throw = 1'b0;
        m_x = int'(`START_X);
        m_y = int'(`START_Y);
        m_dir = 0;
        m_walk = 0;
        m_sprite = 0;
        m_speed = 1;
        m_count = 0;
        m_started = 1'b0;
        m_fight = 1'b0;
        m_present = 1'b0;
        cr_x = 0;
        cr_y = 0;
        cr_w = 0;
        cr_h = 0;
        @(negedge Reset);

        // reset values and idle, then a first key that only starts
        check_outputs();
        check("throw_frame", 32'(throw_frame), 32'd0);
        check("ball_frame", 32'(ball_frame), 32'd0);
        hold_key(8'd0, 3);
        hold_key(`KEY_UP, 1);
        hold_key(8'd0, 1);

        // register access and error responses
        apb_xfer(1'b0, `REG_SPEED, 32'd0);
        apb_xfer(1'b0, `REG_STATUS, 32'd0);
        apb_xfer(1'b1, `REG_SPEED, 32'd2);
        apb_xfer(1'b0, `REG_SPEED, 32'd0);
        apb_xfer(1'b1, `REG_SPEED, 32'd3);
        apb_xfer(1'b1, `REG_STATUS, 32'd1);
        apb_xfer(1'b0, `REG_SPEED, 32'd0);
        apb_xfer(1'b1, `REG_CREATURE_SIZE, {16'd20, 16'd16});
        apb_xfer(1'b0, `REG_CREATURE_SIZE, 32'd0);
        // parked left of the area where the player never reaches
        apb_xfer(1'b1, `REG_CREATURE_POS, {16'd10, 16'd8});
        apb_xfer(1'b0, `REG_CREATURE_POS, 32'd0);

        // random walk at both speeds
        apb_xfer(1'b1, `REG_SPEED, 32'd1);
        random_walk(RAND_SEGS);
        apb_xfer(1'b1, `REG_SPEED, 32'd2);
        random_walk(RAND_SEGS);

        // push into the top, bottom and right edges
        apb_xfer(1'b1, `REG_SPEED, 32'd2);
        hold_key(`KEY_UP, 40);
        hold_key(`KEY_DOWN, 40);
        keycode = `KEY_RIGHT;
        while (m_x < int'(`AREA_X_MAX) - int'(`PLAYER_W))
            clock_edge();
        hold_key(`KEY_RIGHT, 3);
        hold_key(8'd0, 2);

        // creature just left of the player for a bump and an escape
        apb_xfer(1'b1, `REG_SPEED, 32'd1);
        apb_xfer(1'b1, `REG_CREATURE_POS, {16'(m_y), 16'(m_x - 20)});
        hold_key(`KEY_LEFT, 8);
        check("fight after bump", 32'(fight), 32'd1);
        hold_key(`KEY_RUN, 1);
        hold_key(8'd0, 1);
        check("fight after escape", 32'(fight), 32'd0);
        check("count after escape", 32'(caught_count), 32'd0);

        // bump again and catch
        hold_key(`KEY_LEFT, 2);
        catch_creature();
        apb_xfer(1'b0, `REG_STATUS, 32'd0);
        check("count after catch", 32'(caught_count), 32'd1);

        // gone until placed again
        hold_key(`KEY_LEFT, 6);
        check("fight with no creature", 32'(fight), 32'd0);
        apb_xfer(1'b1, `REG_CREATURE_POS, {16'(cr_y), 16'(cr_x)});
        hold_key(`KEY_RIGHT, 1);
        check("fight after re-arm", 32'(fight), 32'd1);
        hold_key(`KEY_RUN, 1);
        hold_key(8'd0, 2);

        $display("errors: %0d, assertion failures: %0d", errors, uut.u_asserts.fail_count);
        if (errors == 0 && uut.u_asserts.fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/overworld_pkg.sv
design/overworld_regs.sv
design/walker.sv
design/catch_sequencer.sv
design/overworld_top.sv
testbench/tb_clock.sv
testbench/overworld_asserts.sv
testbench/overworld_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= overworld_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
